//--- ex_stage.f
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_writeback.sv
verilog/ex_stage.sv
testbench/tb_clock_gen.sv
testbench/tb_ex_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the execute-stage testbench with Verilator, run it, grade by the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f ex_stage.f --top-module tb_ex_stage \
  --Mdir obj_dir -o sim_ex_stage || { echo "Build failed"; exit 1; }

./obj_dir/sim_ex_stage | tee /dev/stderr | grep -q "All tests passed!" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- testbench/ex_stage_trace.txt
# name unit(0 alu,1 mul,2 csr,3 lsu) op a b c flags exp_data exp_flag, all hex
# flags: bit0 alu_we, bit1 regfile_we, bit2 lsu_err, bit3 branch_in_ex
add_basic    0 00 00000005 00000007 00000000 1 0000000c 0
sub_neg      0 01 00000003 00000005 00000000 1 fffffffe 0
sub_equal    0 01 00001234 00001234 00000000 1 00000000 1
and_mask     0 02 f0f0ff00 0ff0f0f0 00000000 1 00f0f000 0
or_mask      0 03 f0f0ff00 0ff0f0f0 00000000 1 fff0fff0 0
xor_mask     0 04 f0f0ff00 0ff0f0f0 00000000 1 ff000ff0 0
sll_max      0 05 00000001 0000001f 00000000 1 80000000 0
sll_wrap     0 05 00000003 00000024 00000000 1 00000030 0
srl_top      0 06 80000000 00000004 00000000 1 08000000 0
sra_top      0 07 80000000 00000004 00000000 1 f8000000 0
slt_neg      0 08 ffffffff 00000001 00000000 1 00000001 0
sltu_big     0 09 ffffffff 00000001 00000000 1 00000000 0
beq_taken    0 10 0000abcd 0000abcd 00000100 8 00000001 1
bne_not      0 11 0000abcd 0000abcd 00000200 8 00000000 0
blt_taken    0 12 fffffff0 00000010 00000300 8 00000001 1
bge_not      0 13 fffffff0 00000010 00000400 8 00000000 0
bltu_not     0 14 fffffff0 00000010 00000500 8 00000000 0
bgeu_taken   0 15 fffffff0 00000010 00000600 8 00000001 1
mul_small    1 00 00000007 00000006 00000000 1 0000002a 0
mul_wrap     1 00 12345678 00000010 00000000 1 23456780 0
mac_add      1 01 00000003 00000004 00000064 1 00000070 0
mulh_min     1 04 80000000 80000000 00000000 1 40000000 1
mulh_neg     1 04 ffffffff 00000002 00000000 1 ffffffff 1
mulhsu_mix   1 05 ffffffff ffffffff 00000000 1 ffffffff 1
mulhu_max    1 06 ffffffff ffffffff 00000000 1 fffffffe 1
csr_over_alu 2 00 00000001 00000002 cafef00d 1 cafef00d 0
load_write   3 00 12345678 00000000 00000000 2 12345678 1
load_err     3 00 0badf00d 00000000 00000000 6 0badf00d 0
load_write2  3 00 a5a5a5a5 00000000 00000000 2 a5a5a5a5 1

//--- testbench/tb_clock_gen.sv
// Clock and reset source for the execute-stage testbench.
// Free-running clock, active-low reset held for the first few cycles
// and released shortly after a rising edge.

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release away from the edge so the async reset never races it
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #10 rst_n_o = 1'b1;
  end

endmodule

//--- testbench/tb_ex_stage.sv
// Trace-driven testbench for the execute stage.
// Reads one instruction per trace line, drives it after the rising edge,
// waits for ex_ready_o and compares the write ports, the branch outputs
// and the EX/WB register with the expected columns of the trace.

module tb_ex_stage;

  timeunit 1ns;
  timeprecision 1ps;

  import ex_pkg::*;

  localparam int unsigned SEED        = 32'h5bfa_f347;
  localparam int          DRIVE_DELAY = 10;
  localparam int          TEST_CYCLES = 12;
  localparam int          MARGIN      = 20;
  localparam string       TRACE_FILE  = "testbench/ex_stage_trace.txt";
  // Unit selector column
  localparam int UNIT_ALU = 0;
  localparam int UNIT_MUL = 1;
  localparam int UNIT_CSR = 2;

  logic clk, rst_n;
  alu_op_e      alu_operator;
  ex_data_t     alu_operand_a, alu_operand_b, alu_operand_c;
  logic         alu_en;
  mult_op_e     mult_operator;
  ex_data_t     mult_operand_a, mult_operand_b, mult_operand_c;
  logic         mult_en, mult_multicycle;
  logic         csr_access, lsu_en, lsu_ready_ex, lsu_err;
  ex_data_t     csr_rdata, lsu_rdata;
  logic         branch_in_ex, regfile_alu_we, regfile_we;
  ex_reg_addr_t regfile_alu_waddr, regfile_waddr;
  logic         regfile_alu_we_fw, regfile_we_wb;
  ex_reg_addr_t regfile_alu_waddr_fw, regfile_waddr_wb;
  ex_data_t     regfile_alu_wdata_fw, regfile_wdata_wb, jump_target;
  logic         branch_decision, ex_ready, ex_valid, wb_ready;

  // Trace columns with one entry per test
  string          t_name[$];
  int             t_unit[$];
  logic [4:0]     t_op[$];
  ex_data_t       t_a[$], t_b[$], t_c[$], t_exp[$];
  logic [3:0]     t_flags[$];
  logic           t_exp_flag[$];

  string cur_name;
  int    test_errors, pass_count, fail_count, num_tests;
  int    cycle_count = 0;
  int    cycle_limit = 0;

  tb_clock_gen u_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  ex_stage u_dut (
    .clk(clk), .rst_n(rst_n),
    .alu_operator_i(alu_operator), .alu_operand_a_i(alu_operand_a),
    .alu_operand_b_i(alu_operand_b), .alu_operand_c_i(alu_operand_c), .alu_en_i(alu_en),
    .mult_operator_i(mult_operator), .mult_operand_a_i(mult_operand_a),
    .mult_operand_b_i(mult_operand_b), .mult_operand_c_i(mult_operand_c),
    .mult_en_i(mult_en), .mult_multicycle_o(mult_multicycle),
    .csr_access_i(csr_access), .csr_rdata_i(csr_rdata), .lsu_en_i(lsu_en),
    .lsu_rdata_i(lsu_rdata), .lsu_ready_ex_i(lsu_ready_ex), .lsu_err_i(lsu_err),
    .branch_in_ex_i(branch_in_ex), .regfile_alu_waddr_i(regfile_alu_waddr),
    .regfile_alu_we_i(regfile_alu_we), .regfile_we_i(regfile_we),
    .regfile_waddr_i(regfile_waddr),
    .regfile_alu_we_fw_o(regfile_alu_we_fw), .regfile_alu_waddr_fw_o(regfile_alu_waddr_fw),
    .regfile_alu_wdata_fw_o(regfile_alu_wdata_fw), .regfile_we_wb_o(regfile_we_wb),
    .regfile_waddr_wb_o(regfile_waddr_wb), .regfile_wdata_wb_o(regfile_wdata_wb),
    .jump_target_o(jump_target), .branch_decision_o(branch_decision),
    .ex_ready_o(ex_ready), .ex_valid_o(ex_valid), .wb_ready_i(wb_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Checks and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %0d ns: %0s %0s got %08h expected %08h",
               $time, cur_name, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("FAIL %0d ns: %0s %0s got %b expected %b", $time, cur_name, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic clear_inputs();
    alu_operator   = ALU_ADD;
    mult_operator  = MUL_MUL;
    alu_operand_a  = '0;
    alu_operand_b  = '0;
    alu_operand_c  = '0;
    mult_operand_a = '0;
    mult_operand_b = '0;
    mult_operand_c = '0;
    csr_rdata      = '0;
    lsu_rdata      = '0;
    {alu_en, mult_en, csr_access, lsu_en, lsu_err} = '0;
    {branch_in_ex, regfile_alu_we, regfile_we} = '0;
    regfile_alu_waddr = '0;
    regfile_waddr     = '0;
  endtask

  task automatic apply_stimulus(input int idx, input ex_reg_addr_t addr);
    clear_inputs();
    case (t_unit[idx])
      UNIT_ALU, UNIT_CSR: begin
        alu_en        = 1'b1;
        alu_operator  = alu_op_e'(t_op[idx]);
        alu_operand_a = t_a[idx];
        alu_operand_b = t_b[idx];
        alu_operand_c = t_c[idx];
        // CSR read data rides on operand c
        csr_access    = (t_unit[idx] == UNIT_CSR);
        csr_rdata     = t_c[idx];
      end
      UNIT_MUL: begin
        mult_en        = 1'b1;
        mult_operator  = mult_op_e'(t_op[idx][2:0]);
        mult_operand_a = t_a[idx];
        mult_operand_b = t_b[idx];
        mult_operand_c = t_c[idx];
      end
      default: begin
        lsu_en    = 1'b1;
        lsu_rdata = t_a[idx];
      end
    endcase
    regfile_alu_we    = t_flags[idx][0];
    regfile_alu_waddr = addr;
    regfile_we        = t_flags[idx][1];
    regfile_waddr     = addr;
    lsu_err           = t_flags[idx][2];
    branch_in_ex      = t_flags[idx][3];
  endtask

  task automatic load_trace(output int count);
    int       fd;
    int       n;
    string    line, nm;
    logic [31:0] u, op, a, b, c, fl, ed, ef;
    count = 0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // Comment and blank lines never yield all nine fields
        if (n > 0 && $sscanf(line, "%s %h %h %h %h %h %h %h %h",
                             nm, u, op, a, b, c, fl, ed, ef) == 9) begin
          t_name.push_back(nm);
          t_unit.push_back(int'(u));
          t_op.push_back(op[4:0]);
          t_a.push_back(a);
          t_b.push_back(b);
          t_c.push_back(c);
          t_flags.push_back(fl[3:0]);
          t_exp.push_back(ed);
          t_exp_flag.push_back(ef[0]);
          count++;
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One instruction, from drive to EX/WB follow-up
  ////////////////////////////////////////////////////////////////////////////

  task automatic verify_result(input int idx, input int waited, input int stalled,
                               input ex_reg_addr_t addr);
    check_bit("ex_valid_o", ex_valid, 1'b1);
    case (t_unit[idx])
      UNIT_ALU: begin
        compare_word("ALU forwarding data", regfile_alu_wdata_fw, t_exp[idx]);
        check_bit("regfile_alu_we_fw_o", regfile_alu_we_fw, t_flags[idx][0]);
        compare_word("regfile_alu_waddr_fw_o", 32'(regfile_alu_waddr_fw), 32'(addr));
        check_bit("branch_decision_o", branch_decision, t_exp_flag[idx]);
        compare_word("jump_target_o", jump_target, t_c[idx]);
      end
      UNIT_MUL: begin
        compare_word("multiplier forwarding data", regfile_alu_wdata_fw, t_exp[idx]);
        check_bit("mult_multicycle_o", mult_multicycle, t_exp_flag[idx]);
        // High words must stall and low words wait only for the WB stall
        if (t_exp_flag[idx]) begin
          assert (waited > stalled) else begin
            $display("%0s: ex_ready_o never dropped for a high-word multiply", cur_name);
            test_errors++;
          end
        end else begin
          assert (waited == stalled) else begin
            $display("%0s: ex_ready_o dropped during a low-word multiply", cur_name);
            test_errors++;
          end
        end
      end
      UNIT_CSR: compare_word("CSR forwarding data", regfile_alu_wdata_fw, t_exp[idx]);
      default:  compare_word("regfile_wdata_wb_o", regfile_wdata_wb, t_exp[idx]);
    endcase
  endtask

  task automatic run_test(input int idx);
    int           stall_left;
    int           stalled;
    int           waited;
    logic         accepted;
    logic         drain_hold;
    ex_reg_addr_t addr;
    cur_name    = t_name[idx];
    test_errors = 0;
    addr        = ex_reg_addr_t'(idx * 5 + 1);
    // Branches bypass the WB handshake, so they get no back-pressure
    stall_left = 0;
    if (!t_flags[idx][3] && ($urandom % 4 == 0)) stall_left = 1 + int'($urandom % 2);
    stalled = stall_left;
    @(posedge clk);
    #(DRIVE_DELAY);
    apply_stimulus(idx, addr);
    wb_ready     = (stall_left == 0);
    waited       = 0;
    accepted     = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      if (!wb_ready) begin
        check_bit("ex_ready_o under stall", ex_ready, 1'b0);
        check_bit("ex_valid_o under stall", ex_valid, 1'b0);
        // The slot was flushed at the first edge and no load got in since
        check_bit("EX/WB enable under stall", regfile_we_wb, 1'b0);
      end else if (ex_ready) begin
        accepted = 1'b1;
      end
      if (!accepted) begin
        waited++;
        @(posedge clk);
        #(DRIVE_DELAY);
        if (stall_left > 0) stall_left--;
        wb_ready = (stall_left == 0);
      end
    end
    verify_result(idx, waited, stalled, addr);
    // Loads may see a stalled WB in the idle slot after acceptance
    @(posedge clk);
    #(DRIVE_DELAY);
    clear_inputs();
    drain_hold = (t_unit[idx] == 3) && ($urandom % 2 == 1);
    wb_ready   = !drain_hold;
    if (t_unit[idx] == 3) begin
      @(negedge clk);
      check_bit("regfile_we_wb_o after load", regfile_we_wb, t_exp_flag[idx]);
      if (t_exp_flag[idx]) begin
        compare_word("regfile_waddr_wb_o", 32'(regfile_waddr_wb), 32'(addr));
      end
      @(posedge clk);
      #(DRIVE_DELAY);
      wb_ready = 1'b1;
      @(negedge clk);
      check_bit("regfile_we_wb_o after WB slot", regfile_we_wb,
                drain_hold ? t_exp_flag[idx] : 1'b0);
    end
    if (test_errors == 0) pass_count++;
    else fail_count++;
    $display("[%0d ns] %0s: %0s", $time, cur_name, (test_errors == 0) ? "ok" : "mismatch");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and cycle limit
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: run exceeded %0d clock cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    clear_inputs();
    wb_ready     = 1'b1;
    lsu_ready_ex = 1'b1;
    pass_count   = 0;
    fail_count   = 0;
    void'($urandom(SEED));
    load_trace(num_tests);
    if (num_tests > 0) begin
      cycle_limit = num_tests * TEST_CYCLES + MARGIN;
      wait (rst_n === 1'b1);
      for (int i = 0; i < num_tests; i++) begin
        run_test(i);
      end
    end else begin
      $display("Could not read any test from %0s", TRACE_FILE);
      fail_count++;
    end
    $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- verilog/ex_alu.sv
// Integer ALU of the execute stage.
// Purely combinational: result and branch condition settle in the same
// cycle as the operands. The comparison output feeds the branch decision.

`include "ex_consts.svh"

module ex_alu (
  input  ex_pkg::alu_op_e  alu_operator_i,
  input  ex_pkg::ex_data_t operand_a_i,
  input  ex_pkg::ex_data_t operand_b_i,
  output ex_pkg::ex_data_t result_o,
  output logic             comparison_result_o
);

  import ex_pkg::*;

  localparam int SHAMT_W = $clog2(`EX_DATA_W);

  logic [SHAMT_W-1:0] shamt;
  ex_data_t           add_result;
  ex_data_t           shift_result;
  logic               is_equal;
  logic               is_less_s;
  logic               is_less_u;
  logic               cmp_result;

  ////////////////////////////////////////////////////////////////////////////
  // Adder and shifter
  ////////////////////////////////////////////////////////////////////////////

  // Only the low bits of b count as shift amount
  assign shamt = operand_b_i[SHAMT_W-1:0];

  // One adder for add and subtract
  assign add_result = (alu_operator_i == ALU_SUB) ? operand_a_i - operand_b_i
                                                  : operand_a_i + operand_b_i;

  always_comb begin
    case (alu_operator_i)
      ALU_SLL: shift_result = operand_a_i << shamt;
      ALU_SRL: shift_result = operand_a_i >> shamt;
      // Arithmetic right shift keeps the sign
      default: shift_result = $signed(operand_a_i) >>> shamt;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Comparisons
  ////////////////////////////////////////////////////////////////////////////

  // Evaluated once, shared by set-less-than and branches
  assign is_equal  = (operand_a_i == operand_b_i);
  assign is_less_s = ($signed(operand_a_i) < $signed(operand_b_i));
  assign is_less_u = (operand_a_i < operand_b_i);

  always_comb begin
    case (alu_operator_i)
      ALU_NE:  cmp_result = ~is_equal;
      ALU_LT:  cmp_result = is_less_s;
      ALU_GE:  cmp_result = ~is_less_s;
      ALU_LTU: cmp_result = is_less_u;
      ALU_GEU: cmp_result = ~is_less_u;
      // EQ and every non-branch operator report equality
      default: cmp_result = is_equal;
    endcase
  end

  assign comparison_result_o = cmp_result;

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_operator_i)
      ALU_ADD, ALU_SUB:          result_o = add_result;
      ALU_AND:                   result_o = operand_a_i & operand_b_i;
      ALU_OR:                    result_o = operand_a_i | operand_b_i;
      ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      ALU_SLT:                   result_o = ex_data_t'(is_less_s);
      ALU_SLTU:                  result_o = ex_data_t'(is_less_u);
      // Branch compares return the condition as a 0/1 word
      default:                   result_o = ex_data_t'(cmp_result);
    endcase
  end

endmodule

//--- verilog/ex_consts.svh
// Shared width and sizing constants for the execute stage.
// Include this header in any file that sizes data paths, operator codes
// or the multicycle multiplier schedule.

`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Operand and result width
`define EX_DATA_W 32

// Register-file address width
// Covers the integer file plus the upper half reserved for other files
`define EX_REG_ADDR_W 6

// ALU operator code width
`define EX_ALU_OP_W 5

// Multiplier operator code width
`define EX_MULT_OP_W 3

// Partial-product steps for a high-word multiply
// Each step is one 16x16 product of operand halves
`define EX_MULT_STEPS 4

`endif

//--- verilog/ex_mult.sv
// Integer multiplier of the execute stage.
// MUL and MAC produce the low word combinationally. The high-word ops
// run a small FSM that sums one 16x16 partial product per cycle and holds
// the upper half until the stage moves on (ex_ready_i).

`include "ex_consts.svh"

module ex_mult (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,
  input  ex_pkg::mult_op_e operator_i,
  input  ex_pkg::ex_data_t op_a_i,
  input  ex_pkg::ex_data_t op_b_i,
  input  ex_pkg::ex_data_t op_c_i,
  input  logic             ex_ready_i,
  output ex_pkg::ex_data_t result_o,
  output logic             multicycle_o,
  output logic             ready_o
);

  import ex_pkg::*;

  localparam int HALF_W  = `EX_DATA_W / 2;
  localparam int ACC_W   = 2 * `EX_DATA_W;
  localparam int PP_W    = 2 * HALF_W + 2;
  localparam int STEP_W  = $clog2(`EX_MULT_STEPS);

  typedef enum logic [1:0] {MH_IDLE, MH_STEP, MH_FINISH} mh_state_e;

  mh_state_e                state_q, state_d;
  logic [STEP_W-1:0]        step_q;
  logic [ACC_W-1:0]         acc_q;
  logic                     is_high;
  logic                     sign_a, sign_b;
  logic signed [HALF_W:0]   pp_a, pp_b;
  logic signed [PP_W-1:0]   pp;
  logic [1:0]               pp_shift;
  logic [ACC_W-1:0]         pp_ext;
  ex_data_t                 low_result;

  assign is_high = operator_i inside {MUL_MULH, MUL_MULHSU, MUL_MULHU};
  // MULHSU treats only a as signed
  assign sign_a  = operator_i inside {MUL_MULH, MUL_MULHSU};
  assign sign_b  = (operator_i == MUL_MULH);

  // Low path, a*b with optional accumulate of c
  assign low_result = op_a_i * op_b_i + ((operator_i == MUL_MAC) ? op_c_i : '0);

  ////////////////////////////////////////////////////////////////////////////
  // Partial products
  ////////////////////////////////////////////////////////////////////////////

  // Step order: lo*lo, lo*hi, hi*lo, hi*hi
  // Low halves are always unsigned, high halves extend per operator
  assign pp_a = step_q[1] ? {sign_a & op_a_i[`EX_DATA_W-1], op_a_i[`EX_DATA_W-1:HALF_W]}
                          : {1'b0, op_a_i[HALF_W-1:0]};
  assign pp_b = step_q[0] ? {sign_b & op_b_i[`EX_DATA_W-1], op_b_i[`EX_DATA_W-1:HALF_W]}
                          : {1'b0, op_b_i[HALF_W-1:0]};
  assign pp   = pp_a * pp_b;

  // Weight in half-words: number of high halves involved
  assign pp_shift = step_q[1] + step_q[0];
  assign pp_ext   = {{(ACC_W-PP_W){pp[PP_W-1]}}, pp} << (pp_shift * HALF_W);

  ////////////////////////////////////////////////////////////////////////////
  // High-word FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MH_IDLE:   if (enable_i && is_high) state_d = MH_STEP;
      MH_STEP:   if (step_q == STEP_W'(`EX_MULT_STEPS - 1)) state_d = MH_FINISH;
      // Hold the result until the stage accepts it
      MH_FINISH: if (ex_ready_i) state_d = MH_IDLE;
      default:   state_d = MH_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MH_IDLE;
      step_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == MH_STEP) begin
        step_q <= step_q + 1'b1;
      end else begin
        step_q <= '0;
      end
    end
  end

  // Accumulator, cleared when a high-word op is accepted
  always_ff @(posedge clk) begin
    if (state_q == MH_IDLE) begin
      acc_q <= '0;
    end else if (state_q == MH_STEP) begin
      acc_q <= acc_q + pp_ext;
    end
  end

  // Busy from the accepting cycle until back in idle
  assign multicycle_o = (state_q != MH_IDLE) || (enable_i && is_high);
  assign ready_o      = (state_q == MH_FINISH) || ((state_q == MH_IDLE) && !(enable_i && is_high));
  assign result_o     = is_high ? acc_q[ACC_W-1:`EX_DATA_W] : low_result;

  // ID must hold the instruction while the partial products run
  a_ops_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == MH_STEP) |-> $stable(operator_i) && $stable(op_a_i) && $stable(op_b_i));

  // Ready stays low through every step and rises right after the last one
  a_high_latency : assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == MH_IDLE && enable_i && is_high) |->
      !ready_o [*(`EX_MULT_STEPS + 1)] ##1 ready_o);

endmodule

//--- verilog/ex_pkg.sv
// Types shared across the execute stage.
// Holds the data and register address types and the operator codes
// that the ID stage drives into the ALU and the multiplier.

`include "ex_consts.svh"

package ex_pkg;

  // Operand or result word
  typedef logic [`EX_DATA_W-1:0] ex_data_t;

  // Register-file write address
  typedef logic [`EX_REG_ADDR_W-1:0] ex_reg_addr_t;

  // ALU operators, arithmetic and logic first, then the branch compares
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD  = 5'h00,
    ALU_SUB  = 5'h01,
    ALU_AND  = 5'h02,
    ALU_OR   = 5'h03,
    ALU_XOR  = 5'h04,
    ALU_SLL  = 5'h05,
    ALU_SRL  = 5'h06,
    ALU_SRA  = 5'h07,
    ALU_SLT  = 5'h08,
    ALU_SLTU = 5'h09,
    ALU_EQ   = 5'h10,
    ALU_NE   = 5'h11,
    ALU_LT   = 5'h12,
    ALU_GE   = 5'h13,
    ALU_LTU  = 5'h14,
    ALU_GEU  = 5'h15
  } alu_op_e;

  // Multiplier operators, high-word variants have the top bit set
  typedef enum logic [`EX_MULT_OP_W-1:0] {
    MUL_MUL    = 3'd0,
    MUL_MAC    = 3'd1,
    MUL_MULH   = 3'd4,
    MUL_MULHSU = 3'd5,
    MUL_MULHU  = 3'd6
  } mult_op_e;

endpackage

//--- verilog/ex_stage.sv
// Execute stage top level.
// Joins the ALU, the multiplier and the write-back ports, and forms the
// valid/ready stall handshake towards ID and WB. Branch decision and
// jump target go straight to the fetch side.

module ex_stage (
  input  logic                 clk,
  input  logic                 rst_n,

  // ALU inputs from ID
  input  ex_pkg::alu_op_e      alu_operator_i,
  input  ex_pkg::ex_data_t     alu_operand_a_i,
  input  ex_pkg::ex_data_t     alu_operand_b_i,
  input  ex_pkg::ex_data_t     alu_operand_c_i,
  input  logic                 alu_en_i,

  // Multiplier inputs from ID
  input  ex_pkg::mult_op_e     mult_operator_i,
  input  ex_pkg::ex_data_t     mult_operand_a_i,
  input  ex_pkg::ex_data_t     mult_operand_b_i,
  input  ex_pkg::ex_data_t     mult_operand_c_i,
  input  logic                 mult_en_i,
  output logic                 mult_multicycle_o,

  // CSR and LSU
  input  logic                 csr_access_i,
  input  ex_pkg::ex_data_t     csr_rdata_i,
  input  logic                 lsu_en_i,
  input  ex_pkg::ex_data_t     lsu_rdata_i,
  input  logic                 lsu_ready_ex_i,
  input  logic                 lsu_err_i,

  // Register-file requests from ID
  input  logic                 branch_in_ex_i,
  input  ex_pkg::ex_reg_addr_t regfile_alu_waddr_i,
  input  logic                 regfile_alu_we_i,
  input  logic                 regfile_we_i,
  input  ex_pkg::ex_reg_addr_t regfile_waddr_i,

  // Write ports
  output logic                 regfile_alu_we_fw_o,
  output ex_pkg::ex_reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::ex_data_t     regfile_alu_wdata_fw_o,
  output logic                 regfile_we_wb_o,
  output ex_pkg::ex_reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::ex_data_t     regfile_wdata_wb_o,

  // To IF
  output ex_pkg::ex_data_t     jump_target_o,
  output logic                 branch_decision_o,

  // Stall handshake
  output logic                 ex_ready_o,
  output logic                 ex_valid_o,
  input  logic                 wb_ready_i
);

  import ex_pkg::*;

  ex_data_t alu_result;
  logic     alu_cmp_result;
  ex_data_t mult_result;
  logic     mult_ready;

  ex_alu u_alu (
    .alu_operator_i      (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .op_c_i       (mult_operand_c_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_writeback u_writeback (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .lsu_err_i              (lsu_err_i),
    .ex_valid_i             (ex_valid_o),
    .wb_ready_i             (wb_ready_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o)
  );

  // Branch target is precomputed by ID on operand c
  assign jump_target_o     = alu_operand_c_i;
  assign branch_decision_o = alu_cmp_result;

  // Branches finish in EX and never wait on WB
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                      & (mult_ready & lsu_ready_ex_i & wb_ready_i);

endmodule

//--- verilog/ex_writeback.sv
// Write-port logic of the execute stage.
// The forwarding port is combinational and picks CSR, multiplier or ALU
// data. The LSU port goes through the EX/WB register, which carries a
// load's write enable and address into the next cycle.

module ex_writeback (
  input  logic                 clk,
  input  logic                 rst_n,

  // Unit enables from ID
  input  logic                 alu_en_i,
  input  logic                 mult_en_i,
  input  logic                 csr_access_i,

  // Candidate write data
  input  ex_pkg::ex_data_t     alu_result_i,
  input  ex_pkg::ex_data_t     mult_result_i,
  input  ex_pkg::ex_data_t     csr_rdata_i,
  input  ex_pkg::ex_data_t     lsu_rdata_i,

  // ALU write port request
  input  logic                 regfile_alu_we_i,
  input  ex_pkg::ex_reg_addr_t regfile_alu_waddr_i,

  // LSU write port request and stage handshake
  input  logic                 regfile_we_i,
  input  logic                 lsu_err_i,
  input  logic                 ex_valid_i,
  input  logic                 wb_ready_i,
  input  ex_pkg::ex_reg_addr_t regfile_waddr_i,

  // Forwarding port, to register file and ID
  output logic                 regfile_alu_we_fw_o,
  output ex_pkg::ex_reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::ex_data_t     regfile_alu_wdata_fw_o,

  // LSU write port
  output logic                 regfile_we_wb_o,
  output ex_pkg::ex_reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::ex_data_t     regfile_wdata_wb_o
);

  import ex_pkg::*;

  logic         we_lsu_q;
  ex_reg_addr_t waddr_lsu_q;
  logic         we_lsu_next;

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Later checks win, so CSR beats multiplier beats ALU
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end
    if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////////////////////

  // A faulting load never writes
  assign we_lsu_next = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q <= 1'b0;
    end else if (ex_valid_i) begin
      we_lsu_q <= we_lsu_next;
    end else if (wb_ready_i) begin
      // WB drained and nothing new, flush the slot
      we_lsu_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i && we_lsu_next) begin
      waddr_lsu_q <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = we_lsu_q;
  assign regfile_waddr_wb_o = waddr_lsu_q;
  // Load data arrives from the LSU in the WB cycle itself
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Decoder issues at most one of ALU and multiplier per instruction
  a_one_unit : assert property (@(posedge clk) disable iff (!rst_n)
    !(alu_en_i && mult_en_i));

endmodule
